//--- logic/irq_settings.svh
// Memory map and vector layout of the handheld CPU; only the low IRQ_NUM_SRC flag bits exist
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// CPU bus addresses of the two interrupt registers
`define IRQ_IE_ADDR 16'hffff // Enable register, top of the map
`define IRQ_IF_ADDR 16'hff0f // Flag register, in the I/O page

// Vector address of source n is IRQ_VEC_BASE + n * IRQ_VEC_STRIDE
`define IRQ_VEC_BASE 16'h0040 // vblank lands here
`define IRQ_VEC_STRIDE 8 // Bytes between handler slots

// Implemented sources, counted from bit 0
// vblank, lcd_stat, timer, serial and joypad in that order.
// IF bits at and above this count are not stored and read back as ones.
`define IRQ_NUM_SRC 5

`endif

//--- logic/irq_pkg.sv
// Types shared by the interrupt controller; the flag layout assumes exactly five named sources
`default_nettype none

package irq_pkg;

	// One CPU bus cycle as seen by the register block
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr; // Write strobe for this cycle
		logic        rd; // Read strobe, rdata idles at 8'hff otherwise
	} cpu_bus_s;

	// Named view of an IE or IF byte, bit 0 is the highest priority
	typedef struct packed {
		logic [2:0] unused; // Bits 7 to 5, no source behind them
		logic       joypad;
		logic       serial;
		logic       timer;
		logic       lcd_stat;
		logic       vblank;
	} irq_src_s;

	// The bus side sees a plain byte, the arbiter sees named sources
	typedef union packed {
		logic [7:0] raw;
		irq_src_s   src;
	} irq_flags_u;

	// Vector handed to the CPU in the cycle after an accepted ack
	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
	} irq_vec_s;

endpackage

`default_nettype wire

//--- logic/irq_regs.sv
// IE keeps all 8 bits but IF stores only IRQ_NUM_SRC bits; any unmapped or non-read cycle gives 8'hff
`timescale 1ns/1ps
`default_nettype none

`include "irq_settings.svh"

module irq_regs import irq_pkg::*; (
	input  wire              clk,
	input  wire              rst,
	input  wire cpu_bus_s    bus,
	input  wire logic [7:0]  trig,     // Source pulses, one cycle each
	input  wire logic [7:0]  clr_mask, // From the dispatcher on an accepted ack
	output logic [7:0]       rdata,
	output irq_flags_u       ie_q,
	output irq_flags_u       if_q
);

	localparam int NSRC = `IRQ_NUM_SRC;
	localparam int PAD  = 8 - NSRC; // Flag bits with no storage

	logic [7:0]      ie_bits;
	logic [NSRC-1:0] if_bits;
	logic [NSRC-1:0] if_base;
	logic [NSRC-1:0] if_next;
	logic [7:0]      rd_mux;
	logic            ie_sel;
	logic            if_sel;

	// Address decode
	assign ie_sel = (bus.addr == `IRQ_IE_ADDR);
	assign if_sel = (bus.addr == `IRQ_IF_ADDR);

	// Bus write replaces, then the ack clears, then triggers set
	always_comb begin
		if_base = (bus.wr && if_sel) ? bus.wdata[NSRC-1:0] : if_bits;
		if_next = (if_base & ~clr_mask[NSRC-1:0]) | trig[NSRC-1:0]; // Trigger wins
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ie_bits <= '0;
			if_bits <= '0;
		end else begin
			if (bus.wr && ie_sel)
				ie_bits <= bus.wdata;
			if_bits <= if_next;
		end
	end

	// Read mux
	always_comb begin
		rd_mux = 8'hff; // Open bus
		if (ie_sel)
			rd_mux = ie_bits;
		else if (if_sel)
			rd_mux = {{PAD{1'b1}}, if_bits}; // Missing flags read high
	end

	assign rdata = bus.rd ? rd_mux : 8'hff;

	// The arbiter sees zeros in the flag bits that have no storage
	assign ie_q.raw = ie_bits;
	assign if_q.raw = {{PAD{1'b0}}, if_bits};

endmodule

`default_nettype wire

//--- logic/irq_arbiter.sv
// Purely combinational fixed priority with bit 0 highest; IE bits 7 to 5 never yield a request
`timescale 1ns/1ps
`default_nettype none

`include "irq_settings.svh"

module irq_arbiter import irq_pkg::*; (
	input  wire irq_flags_u ie_q,
	input  wire irq_flags_u if_q,
	output logic            pending,  // Some enabled source is flagged
	output logic [2:0]      win_idx,  // Index of the winning source
	output logic [7:0]      win_mask  // One-hot copy of win_idx
);

	localparam int NSRC = `IRQ_NUM_SRC;

	irq_flags_u live; // Enabled and flagged, built per source

	// Gate each named source with its own enable
	always_comb begin
		live.src.vblank   = ie_q.src.vblank   & if_q.src.vblank;
		live.src.lcd_stat = ie_q.src.lcd_stat & if_q.src.lcd_stat;
		live.src.timer    = ie_q.src.timer    & if_q.src.timer;
		live.src.serial   = ie_q.src.serial   & if_q.src.serial;
		live.src.joypad   = ie_q.src.joypad   & if_q.src.joypad;
		live.src.unused   = '0; // Enable alone is not a request
	end

	assign pending = |live.raw;

	// Scan from the top so the lowest set bit is left standing
	always_comb begin
		win_idx  = '0;
		win_mask = '0;
		for (int i = NSRC - 1; i >= 0; i--) begin
			if (live.raw[i]) begin
				win_idx  = 3'(i);
				win_mask = 8'(1) << i;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/irq_dispatch.sv
// IME takes effect on the edge after ei with no extra delay; one dispatch in flight at a time
`timescale 1ns/1ps
`default_nettype none

`include "irq_settings.svh"

module irq_dispatch import irq_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire             ei,
	input  wire             di,
	input  wire             pending,
	input  wire logic [2:0] win_idx,
	input  wire logic [7:0] win_mask,
	input  wire             irq_ack,
	output logic            irq_req,
	output logic [7:0]      clr_mask,
	output irq_vec_s        vec
);

	logic       ime;
	logic       ack_ok;  // Ack seen while a request is up
	logic       vec_vld;
	logic [2:0] vec_idx; // Source taken on the last ack

	assign irq_req = ime & pending;
	assign ack_ok  = irq_ack & irq_req; // A stray ack does nothing

	// Winning flag drops at the same edge that samples the ack
	assign clr_mask = ack_ok ? win_mask : 8'h00;

	// Master enable
	always_ff @(posedge clk) begin
		if (rst)
			ime <= 1'b0;
		else if (ack_ok || di) // Dispatch and di both close the gate
			ime <= 1'b0;
		else if (ei)
			ime <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			vec_vld <= 1'b0;
		else
			vec_vld <= ack_ok; // Single cycle pulse
	end

	always_ff @(posedge clk) begin
		if (ack_ok)
			vec_idx <= win_idx;
	end

	// Handler address from the registered index
	assign vec.valid = vec_vld;
	assign vec.addr  = `IRQ_VEC_BASE + 16'(vec_idx) * 16'(`IRQ_VEC_STRIDE);

endmodule

`default_nettype wire

//--- logic/irq_top.sv
// Single clock and separate read data in place of the shared data bus; no HALT wake-up
`timescale 1ns/1ps
`default_nettype none

module irq_top import irq_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire cpu_bus_s   bus,
	input  wire logic [7:0] trig,
	input  wire             ei,
	input  wire             di,
	input  wire             irq_ack,
	output logic [7:0]      rdata,
	output logic            irq_req,
	output irq_vec_s        vec
);

	irq_flags_u ie_q;
	irq_flags_u if_q;
	logic       pending;
	logic [2:0] win_idx;
	logic [7:0] win_mask;
	logic [7:0] clr_mask;

	irq_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.bus      (bus),
		.trig     (trig),
		.clr_mask (clr_mask),
		.rdata    (rdata),
		.ie_q     (ie_q),
		.if_q     (if_q)
	);

	irq_arbiter u_arbiter (
		.ie_q     (ie_q),
		.if_q     (if_q),
		.pending  (pending),
		.win_idx  (win_idx),
		.win_mask (win_mask)
	);

	irq_dispatch u_dispatch (
		.clk      (clk),
		.rst      (rst),
		.ei       (ei),
		.di       (di),
		.pending  (pending),
		.win_idx  (win_idx),
		.win_mask (win_mask),
		.irq_ack  (irq_ack),
		.irq_req  (irq_req),
		.clr_mask (clr_mask), // Back into IF
		.vec      (vec)
	);

endmodule

`default_nettype wire

//--- test/irq_properties.sv
// Protocol checks on irq_top ports only; every property is off while rst is high
`timescale 1ns/1ps
`default_nettype none

`include "irq_settings.svh"

module irq_properties import irq_pkg::*; (
	input wire             clk,
	input wire             rst,
	input wire cpu_bus_s   bus,
	input wire logic [7:0] rdata,
	input wire             irq_ack,
	input wire             irq_req,
	input wire irq_vec_s   vec
);

	vec_one_cycle: assert property (@(posedge clk) disable iff (rst)
		vec.valid |=> !vec.valid)
		else $error("vec.valid stayed high for more than one cycle");

	vec_after_ack: assert property (@(posedge clk) disable iff (rst)
		vec.valid |-> $past(irq_ack && irq_req))
		else $error("vec.valid without an accepted ack in the cycle before");

	// An accepted ack drops IME, so the request must fall
	req_low_after_ack: assert property (@(posedge clk) disable iff (rst)
		(irq_ack && irq_req) |=> !irq_req)
		else $error("irq_req still high in the cycle after an ack");

	if_top_bits_ones: assert property (@(posedge clk) disable iff (rst)
		(bus.rd && bus.addr == `IRQ_IF_ADDR) |-> (rdata[7:5] == 3'b111))
		else $error("IF read with bits 7 to 5 not all ones");

endmodule

`default_nettype wire

//--- test/irq_checker.sv
// Samples DUT outputs on the falling edge, when inputs driven after the rising edge have settled
`timescale 1ns/1ps
`default_nettype none

module irq_checker import irq_pkg::*; (
	input  wire              clk,
	input  wire logic [7:0]  rdata,
	input  wire              irq_req,
	input  wire irq_vec_s    vec,
	input  wire              chk_en,   // One compare per row
	input  wire logic [1:0]  chk_kind,
	input  wire logic [16:0] chk_exp,
	output int               n_tests,
	output int               n_errors
);

	localparam logic [1:0] K_RDATA = 2'd0;
	localparam logic [1:0] K_VEC   = 2'd2;

	string       test_name; // Written by the testbench for each row
	int          tests  = 0;
	int          errors = 0;
	logic [16:0] act;
	logic        ok;

	assign n_tests  = tests;
	assign n_errors = errors;

	always @(negedge clk) begin
		if (chk_en) begin
			case (chk_kind)
				K_RDATA: begin
					act = {9'd0, rdata};
					ok  = (rdata == chk_exp[7:0]);
				end
				K_VEC: begin
					act = vec;
					ok  = chk_exp[16] ? (vec == chk_exp) : !vec.valid; // No vector expected
				end
				default: begin
					act = {16'd0, irq_req};
					ok  = (irq_req == chk_exp[0]);
				end
			endcase
			tests <= tests + 1;
			if (ok) begin
				$display("ok       %s", test_name);
			end else begin
				errors <= errors + 1;
				$display("** Error %s: expected %h, actual %h", test_name, chk_exp, act);
			end
		end
	end

endmodule

`default_nettype wire

//--- test/irq_tb.sv
// Drives irq_top 5 ns after each rising edge; expected values come from the register and vector rules
`timescale 1ns/1ps
`default_nettype none

`include "irq_settings.svh"

module irq_tb import irq_pkg::*; ();

	localparam logic [2:0] OP_RD   = 3'd0;
	localparam logic [2:0] OP_WR   = 3'd1;
	localparam logic [2:0] OP_TRIG = 3'd2;
	localparam logic [2:0] OP_EI   = 3'd3;
	localparam logic [2:0] OP_DI   = 3'd4;
	localparam logic [2:0] OP_ACK  = 3'd5;
	localparam logic [2:0] OP_IDLE = 3'd6;

	localparam logic [1:0] K_RDATA = 2'd0;
	localparam logic [1:0] K_REQ   = 2'd1;
	localparam logic [1:0] K_VEC   = 2'd2;

	localparam logic [7:0] SRC_MASK = 8'((1 << `IRQ_NUM_SRC) - 1); // Implemented flag bits

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [16:0] exp; // rdata, irq_req in bit 0, or {valid, addr}
	} row_s;

	logic        clk = 1'b0;
	logic        rst;
	cpu_bus_s    bus;
	logic [7:0]  trig;
	logic        ei;
	logic        di;
	logic        irq_ack;
	logic [7:0]  rdata;
	logic        irq_req;
	irq_vec_s    vec;
	logic        chk_en;
	logic [1:0]  chk_kind;
	logic [16:0] chk_exp;
	int          n_tests;
	int          n_errors;
	row_s        rows[$];
	string       row_names[$];
	logic [31:0] seed;
	int          limit_ns;

	always #50 clk = ~clk;

	irq_top uut (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.trig    (trig),
		.ei      (ei),
		.di      (di),
		.irq_ack (irq_ack),
		.rdata   (rdata),
		.irq_req (irq_req),
		.vec     (vec)
	);

	irq_checker chk (
		.clk      (clk),
		.rdata    (rdata),
		.irq_req  (irq_req),
		.vec      (vec),
		.chk_en   (chk_en),
		.chk_kind (chk_kind),
		.chk_exp  (chk_exp),
		.n_tests  (n_tests),
		.n_errors (n_errors)
	);

	bind irq_top irq_properties props (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.rdata   (rdata),
		.irq_ack (irq_ack),
		.irq_req (irq_req),
		.vec     (vec)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Lowest enabled and flagged source wins, bit 0 first
	function automatic logic [16:0] expected_vec(input logic [7:0] en, input logic [7:0] fl);
		logic [7:0]  hit;
		logic [16:0] v;
		hit = en & fl & SRC_MASK;
		v = '0;
		for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
			if (hit[i] && !v[16])
				v = {1'b1, 16'(`IRQ_VEC_BASE + `IRQ_VEC_STRIDE * i)};
		end
		return v;
	endfunction

	task automatic add_row(input string name, input logic [2:0] op, input logic [15:0] addr,
			input logic [7:0] data, input logic [16:0] exp);
		row_s r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic build_fixed_rows();
		add_row("rst_ie_read",       OP_RD,   `IRQ_IE_ADDR, 8'h00, 17'h000_00);
		add_row("rst_if_read",       OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_e0);
		add_row("rst_req_low",       OP_IDLE, 16'h0000,     8'h00, 17'h0);
		add_row("ie_write",          OP_WR,   `IRQ_IE_ADDR, 8'h15, 17'h0);
		add_row("ie_readback",       OP_RD,   `IRQ_IE_ADDR, 8'h00, 17'h000_15);
		add_row("if_write_ones",     OP_WR,   `IRQ_IF_ADDR, 8'hff, 17'h0);
		add_row("if_readback_ff",    OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_ff);
		add_row("if_write_0a",       OP_WR,   `IRQ_IF_ADDR, 8'h0a, 17'h0);
		add_row("if_readback_0a",    OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_ea);
		add_row("open_bus_ff10",     OP_RD,   16'hff10,     8'h00, 17'h000_ff);
		add_row("open_bus_0000",     OP_RD,   16'h0000,     8'h00, 17'h000_ff);
		add_row("if_clear",          OP_WR,   `IRQ_IF_ADDR, 8'h00, 17'h0);
		add_row("trig_timer",        OP_TRIG, 16'h0000,     8'h04, 17'h0);
		add_row("trig_timer_read",   OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_e4);
		add_row("trig_beats_write",  OP_TRIG, `IRQ_IF_ADDR, 8'h02, 17'h0); // Clearing write too
		add_row("trig_beats_read",   OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_e2);
		add_row("ie_write_1e",       OP_WR,   `IRQ_IE_ADDR, 8'h1e, 17'h0);
		add_row("trig_multi",        OP_TRIG, 16'h0000,     8'h1c, 17'h0);
		add_row("ei_req_high",       OP_EI,   16'h0000,     8'h00, 17'h1);
		add_row("ack_lcd_stat",      OP_ACK,  16'h0000,     8'h00, 17'h1_0048);
		add_row("ack_if_read",       OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_fc);
		add_row("ime_cleared",       OP_IDLE, 16'h0000,     8'h00, 17'h0);
		add_row("ei_again",          OP_EI,   16'h0000,     8'h00, 17'h1);
		add_row("di_masks",          OP_DI,   16'h0000,     8'h00, 17'h0);
		add_row("ack_stray",         OP_ACK,  16'h0000,     8'h00, 17'h0);
		add_row("stray_if_read",     OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_fc);
		add_row("ie_unused_only",    OP_WR,   `IRQ_IE_ADDR, 8'he0, 17'h0);
		add_row("ei_unused_only",    OP_EI,   16'h0000,     8'h00, 17'h0);
		add_row("ack_unused_only",   OP_ACK,  16'h0000,     8'h00, 17'h0);
		add_row("ie_none",           OP_WR,   `IRQ_IE_ADDR, 8'h00, 17'h0);
		add_row("flags_not_enabled", OP_IDLE, 16'h0000,     8'h00, 17'h0);
		add_row("ack_not_enabled",   OP_ACK,  16'h0000,     8'h00, 17'h0);
		add_row("ie_joypad",         OP_WR,   `IRQ_IE_ADDR, 8'h10, 17'h1); // IME still on
		add_row("ack_joypad",        OP_ACK,  16'h0000,     8'h00, 17'h1_0060);
		add_row("joypad_if_read",    OP_RD,   `IRQ_IF_ADDR, 8'h00, 17'h000_ec);
		add_row("joypad_req_low",    OP_IDLE, 16'h0000,     8'h00, 17'h0);
	endtask

	// Each random case starts from a closed gate and a cleared IF
	task automatic build_random_rows();
		logic [7:0] en;
		logic [7:0] fl;
		for (int n = 0; n < 20; n++) begin
			seed = lcg_next(seed);
			en = seed[23:16];
			seed = lcg_next(seed);
			fl = seed[23:16];
			add_row($sformatf("rnd%0d_di", n), OP_DI, 16'h0000, 8'h00, 17'h0);
			add_row($sformatf("rnd%0d_ie", n), OP_WR, `IRQ_IE_ADDR, en, 17'h0);
			add_row($sformatf("rnd%0d_ifclr", n), OP_WR, `IRQ_IF_ADDR, 8'h00, 17'h0);
			add_row($sformatf("rnd%0d_trig", n), OP_TRIG, 16'h0000, fl, 17'h0);
			add_row($sformatf("rnd%0d_ei", n), OP_EI, 16'h0000, 8'h00,
				{16'h0000, |(en & fl & SRC_MASK)});
			add_row($sformatf("rnd%0d_ack", n), OP_ACK, 16'h0000, 8'h00, expected_vec(en, fl));
		end
	endtask

	task automatic idle_inputs();
		bus     = '0;
		trig    = 8'h00;
		ei      = 1'b0;
		di      = 1'b0;
		irq_ack = 1'b0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	// Reads check in the same cycle and everything else in the cycle after
	task automatic apply_row(input int idx);
		row_s r;
		r = rows[idx];
		chk.test_name = row_names[idx];
		chk_exp = r.exp;
		if (r.op == OP_RD) begin
			bus.addr = r.addr;
			bus.rd   = 1'b1;
			chk_kind = K_RDATA;
			chk_en   = 1'b1;
			next_cycle();
		end else if (r.op == OP_IDLE) begin
			chk_kind = K_REQ;
			chk_en   = 1'b1;
			next_cycle();
		end else begin
			if (r.op == OP_WR) begin
				bus.addr  = r.addr;
				bus.wdata = r.data;
				bus.wr    = 1'b1;
			end else if (r.op == OP_TRIG) begin
				trig = r.data;
				if (r.addr == `IRQ_IF_ADDR) begin
					bus.addr  = r.addr;
					bus.wdata = 8'h00;
					bus.wr    = 1'b1;
				end
			end else if (r.op == OP_EI) begin
				ei = 1'b1;
			end else if (r.op == OP_DI) begin
				di = 1'b1;
			end else begin
				irq_ack = 1'b1;
			end
			next_cycle();
			idle_inputs();
			chk_kind = (r.op == OP_ACK) ? K_VEC : K_REQ;
			chk_en   = 1'b1;
			next_cycle();
		end
		chk_en = 1'b0;
		idle_inputs();
	endtask

	initial begin
		idle_inputs();
		rst      = 1'b1;
		chk_en   = 1'b0;
		chk_kind = K_REQ;
		chk_exp  = '0;
		seed     = 32'hdc2e;
		build_fixed_rows();
		build_random_rows();
		limit_ns = (rows.size() * 4 + 20) * 100; // Twice the worst case of two cycles per row
		fork
			begin
				#(limit_ns);
				$display("Timeout: the run did not finish within %0d ns", limit_ns);
				$display("SOME TESTS FAILED");
				$finish;
			end
		join_none
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;
		for (int i = 0; i < rows.size(); i++)
			apply_row(i);
		next_cycle();
		$display("Summary: %0d tests, %0d passed, %0d failed",
			n_tests, n_tests - n_errors, n_errors);
		if (n_tests != rows.size())
			$display("The checker compared %0d rows but %0d were applied", n_tests, rows.size());
		if (n_errors == 0 && n_tests == rows.size())
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/irq_pkg.sv
logic/irq_regs.sv
logic/irq_arbiter.sv
logic/irq_dispatch.sv
logic/irq_top.sv
test/irq_properties.sv
test/irq_checker.sv
test/irq_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = irq_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
